/* project.f */
+incdir+.
mcu_pkg.sv
code_rom.sv
mcu_core.sv
tx_dispatch.sv
uart_tx_chan.sv
tx_collect.sv
mcu_top.sv
tb_mcu_top.sv

/* run_sim.sh */
#!/bin/sh
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -Wno-fatal -f project.f --top-module tb_mcu_top \
    -Mdir obj_dir > build.log 2>&1 || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/Vtb_mcu_top > sim.log 2>&1
cat sim.log
grep -qx "sim passed" sim.log && exit 0 || exit 1

/* tb_mcu_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcu_params.svh"

module tb_mcu_top;

    localparam int NUM_ENTRIES = 6;
    // one serial bit, 4 ticks of the divided clock
    localparam int BIT_CYC     = `MCU_BAUD_DIV * 4;
    localparam int HALF_BIT    = BIT_CYC / 2;
    // strobe held high after the frames, no second frame allowed
    localparam int QUIET_CYC   = 3 * BIT_CYC;
    // time for the core to see the strobe drop
    localparam int GAP_CYC     = 40;
    localparam int TIMEOUT_CYC = NUM_ENTRIES * 3000;

    // one table row, stimulus plus expected results
    typedef struct packed {
        logic [7:0] data;
        logic [7:0] exp_ch0;
        logic [7:0] exp_ch1;
        logic [7:0] exp_leds;
    } vec_t;

    logic                   clk50m;
    logic                   rst_n;
    logic [`MCU_WORD-1:0]   ext_data;
    logic [7:0]             leds;
    logic [`MCU_NUM_TX-1:0] txd;

    vec_t        vectors [NUM_ENTRIES];
    logic [15:0] lfsr_state = 16'd10615;
    int          cycle_cnt = 0;

    mcu_top u_dut (
        .clk50m   (clk50m),
        .rst_n    (rst_n),
        .ext_data (ext_data),
        .leds     (leds),
        .txd      (txd)
    );

    // 50 MHz
    always #10 clk50m = ~clk50m;

    // run limit
    always @(posedge clk50m) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt >= TIMEOUT_CYC) begin
            $display("timeout: no frame seen");
            $display("sim failed");
            $fatal(1, "cycle limit of %0d reached", TIMEOUT_CYC);
        end
    end

    // x^16 + x^14 + x^13 + x^11 + 1, shifts toward msb
    function automatic logic [15:0] lfsr_next(input logic [15:0] s);
        logic fb;
        fb = s[15] ^ s[13] ^ s[12] ^ s[10];
        return {s[14:0], fb};
    endfunction

    // one lfsr step per bit taken
    task automatic next_random_byte(output logic [7:0] b);
        for (int i = 0; i < 8; i++) begin
            lfsr_state = lfsr_next(lfsr_state);
            b[i] = lfsr_state[0];
        end
    endtask

    task automatic check_byte(input string name, input logic [7:0] got,
                              input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
            $display("sim failed");
            $fatal(1, "byte mismatch");
        end
    endtask

    task automatic check_leds(input logic [7:0] got, input logic [7:0] exp);
        if (got !== exp) begin
            $display("Fail leds got 0x%h expected 0x%h", got, exp);
            $display("sim failed");
            $fatal(1, "led count mismatch");
        end
    endtask

    task automatic check_line(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("Fail %s got 0x%h expected 0x%h", name, got, exp);
            $display("sim failed");
            $fatal(1, "serial line mismatch");
        end
    endtask

    // both lines must idle high for the whole window
    task automatic expect_idle_lines(input int cycles);
        repeat (cycles) begin
            @(negedge clk50m);
            check_line("txd[0] idle", txd[0], 1'b1);
            check_line("txd[1] idle", txd[1], 1'b1);
        end
    endtask

    // leds moves once the program has seen both done flags
    task automatic wait_leds_change(input logic [7:0] prev);
        @(negedge clk50m);
        while (leds === prev) begin
            check_line("txd[0] idle", txd[0], 1'b1);
            check_line("txd[1] idle", txd[1], 1'b1);
            @(negedge clk50m);
        end
    endtask

    // start bit length varies with the tick phase, later bits are full length
    task automatic receive_frame(input int ch, output logic [7:0] data);
        logic [7:0] d;
        @(negedge clk50m);
        while (txd[ch] !== 1'b0) begin
            @(negedge clk50m);
        end
        repeat (HALF_BIT) @(negedge clk50m);
        check_line(ch == 0 ? "txd[0] start" : "txd[1] start", txd[ch], 1'b0);
        // data bits, lsb first
        for (int k = 0; k < 8; k++) begin
            repeat (BIT_CYC) @(negedge clk50m);
            d[k] = txd[ch];
        end
        repeat (BIT_CYC) @(negedge clk50m);
        check_line(ch == 0 ? "txd[0] stop" : "txd[1] stop", txd[ch], 1'b1);
        data = d;
    endtask

    initial begin
        vec_t       v;
        logic [7:0] got0;
        logic [7:0] got1;
        logic [7:0] rnd;
        clk50m   = 1'b0;
        rst_n    = 1'b0;
        ext_data = '0;

        // fixed corners plus lfsr bytes
        for (int n = 0; n < NUM_ENTRIES; n++) begin
            if (n == 0) begin
                rnd = 8'h00;
            end else if (n == 2) begin
                rnd = 8'hff;
            end else begin
                next_random_byte(rnd);
            end
            vectors[n].data     = rnd;
            vectors[n].exp_ch0  = rnd;
            vectors[n].exp_ch1  = ~rnd;
            vectors[n].exp_leds = 8'(n + 1);
        end

        repeat (3) @(posedge clk50m);
        rst_n <= 1'b1;

        // quiet lines and zero count before any strobe
        expect_idle_lines(300);
        check_leds(leds, 8'h00);

        for (int n = 0; n < NUM_ENTRIES; n++) begin
            v = vectors[n];
            // strobe in bit 15, junk above the byte must be masked
            @(posedge clk50m);
            ext_data <= {1'b1, 7'h2a, v.data};
            fork
                receive_frame(0, got0);
                receive_frame(1, got1);
            join
            check_byte("txd[0] byte", got0, v.exp_ch0);
            check_byte("txd[1] byte", got1, v.exp_ch1);
            wait_leds_change(v.exp_leds - 8'd1);
            check_leds(leds, v.exp_leds);
            // strobe still high
            expect_idle_lines(QUIET_CYC);
            @(posedge clk50m);
            ext_data <= {1'b0, 7'h2a, v.data};
            expect_idle_lines(GAP_CYC);
        end

        $display("sim passed");
        $finish;
    end

endmodule

`default_nettype wire

/* mcu_top.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcu_params.svh"

module mcu_top (
    input  wire logic                   clk50m,
    input  wire logic                   rst_n,
    input  wire logic [`MCU_WORD-1:0]   ext_data,
    output wire logic [7:0]             leds,
    output wire logic [`MCU_NUM_TX-1:0] txd
);
    import mcu_pkg::*;

    localparam int W = `MCU_WORD;

    wire logic [`MCU_CODE_AW-1:0]          code_addr;
    instr_t                                instr;
    wire logic [`MCU_NUM_REGS*W-1:0]       regs;
    wire logic [`MCU_NUM_DIN*W-1:0]        din;
    wire logic                             tick;
    tx_cmd_t                               tx_cmd [`MCU_NUM_TX];
    tx_stat_t                              tx_stat [`MCU_NUM_TX];
    wire logic [W-1:0]                     status;

    code_rom u_rom (
        .clk50m    (clk50m),
        .rst_n     (rst_n),
        .code_addr (code_addr),
        .instr     (instr)
    );

    mcu_core u_core (
        .clk50m    (clk50m),
        .rst_n     (rst_n),
        .code_addr (code_addr),
        .instr     (instr),
        .din       (din),
        .regs      (regs)
    );

    // data input slots, unused ones read zero
    for (genvar i = 0; i < `MCU_NUM_DIN; i++) begin : g_din
        if (i == `MCU_DIN_STATUS) begin : g_stat
            assign din[i*W +: W] = status;
        end else if (i == `MCU_DIN_EXT) begin : g_ext
            assign din[i*W +: W] = ext_data;
        end else begin : g_zero
            assign din[i*W +: W] = '0;
        end
    end

    tx_dispatch u_dispatch (
        .clk50m (clk50m),
        .rst_n  (rst_n),
        .regs   (regs),
        .tick   (tick),
        .tx_cmd (tx_cmd)
    );

    // identical channels share the tick
    for (genvar c = 0; c < `MCU_NUM_TX; c++) begin : g_tx
        uart_tx_chan u_tx (
            .clk50m  (clk50m),
            .rst_n   (rst_n),
            .tick    (tick),
            .tx_cmd  (tx_cmd[c]),
            .txd     (txd[c]),
            .tx_stat (tx_stat[c])
        );
    end

    tx_collect u_collect (
        .clk50m  (clk50m),
        .rst_n   (rst_n),
        .tx_stat (tx_stat),
        .regs    (regs),
        .status  (status)
    );

    // counter register low byte
    assign leds = regs[`MCU_REG_LED*W +: 8];

endmodule

`default_nettype wire

/* tx_collect.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcu_params.svh"

module tx_collect (
    input  wire logic                               clk50m,
    input  wire logic                               rst_n,
    input  wire mcu_pkg::tx_stat_t                  tx_stat [`MCU_NUM_TX],
    input  wire logic [`MCU_NUM_REGS*`MCU_WORD-1:0] regs,
    output logic [`MCU_WORD-1:0]                    status
);

    logic [`MCU_NUM_TX-1:0] busy_now;
    logic [`MCU_NUM_TX-1:0] busy_prev;
    logic [`MCU_NUM_TX-1:0] busy_fall;
    logic [`MCU_NUM_TX-1:0] done;
    logic                   ack_now;
    logic                   ack_prev;
    logic                   ack_rise;

    always_comb begin
        for (int c = 0; c < `MCU_NUM_TX; c++) begin
            busy_now[c] = tx_stat[c].busy;
        end
    end

    assign busy_fall = busy_prev & ~busy_now;
    // ack register bit 0
    assign ack_now   = regs[`MCU_REG_ACK*`MCU_WORD];
    assign ack_rise  = ack_now & ~ack_prev;

    always_ff @(posedge clk50m or negedge rst_n) begin
        if (!rst_n) begin
            busy_prev <= '0;
            ack_prev  <= 1'b0;
            done      <= '0;
        end else begin
            busy_prev <= busy_now;
            ack_prev  <= ack_now;
            // clear all on ack, a fresh fall still sets its flag
            done      <= (ack_rise ? '0 : done) | busy_fall;
        end
    end

    // flags in the low bits, rest zero
    assign status = {{(`MCU_WORD-`MCU_NUM_TX){1'b0}}, done};

endmodule

`default_nettype wire

/* uart_tx_chan.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcu_params.svh"

module uart_tx_chan (
    input  wire logic             clk50m,
    input  wire logic             rst_n,
    input  wire logic             tick,
    input  wire mcu_pkg::tx_cmd_t tx_cmd,
    output logic                  txd,
    output mcu_pkg::tx_stat_t     tx_stat
);
    import mcu_pkg::*;

    localparam int TW = $clog2(`MCU_OVERSAMPLE);

    uart_state_e    state;
    logic [TW-1:0]  tick_cnt;
    logic [2:0]     bit_cnt;
    logic [7:0]     shift;
    logic           bit_end;
    logic           accept;
    logic           line_next;

    // last tick of the current bit
    assign bit_end = tick && (tick_cnt == TW'(`MCU_OVERSAMPLE - 1));
    // loads while busy are dropped
    assign accept  = (state == TX_IDLE) && tx_cmd.load;

    always_ff @(posedge clk50m or negedge rst_n) begin
        if (!rst_n) begin
            state    <= TX_IDLE;
            tick_cnt <= '0;
            bit_cnt  <= '0;
        end else begin
            if (accept) begin
                state    <= TX_START;
                tick_cnt <= '0;
            end else if (state != TX_IDLE && tick) begin
                tick_cnt <= tick_cnt + 1'b1;
            end
            if (bit_end) begin
                case (state)
                    TX_START: begin
                        state   <= TX_DATA;
                        bit_cnt <= '0;
                    end
                    TX_DATA: begin
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == 3'd7) begin
                            state <= TX_STOP;
                        end
                    end
                    TX_STOP: state <= TX_IDLE;
                    default: state <= TX_IDLE;
                endcase
            end
        end
    end

    // payload, lsb first
    always_ff @(posedge clk50m) begin
        if (accept) begin
            shift <= tx_cmd.data;
        end else if (state == TX_DATA && bit_end) begin
            shift <= shift >> 1;
        end
    end

    always_comb begin
        case (state)
            TX_START: line_next = 1'b0;
            TX_DATA:  line_next = shift[0];
            default:  line_next = 1'b1;
        endcase
    end

    // registered line, idles high
    always_ff @(posedge clk50m or negedge rst_n) begin
        if (!rst_n) begin
            txd <= 1'b1;
        end else begin
            txd <= line_next;
        end
    end

    assign tx_stat.busy = (state != TX_IDLE);

endmodule

`default_nettype wire

/* tx_dispatch.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcu_params.svh"

module tx_dispatch (
    input  wire logic                               clk50m,
    input  wire logic                               rst_n,
    input  wire logic [`MCU_NUM_REGS*`MCU_WORD-1:0] regs,
    output logic                                    tick,
    output mcu_pkg::tx_cmd_t                        tx_cmd [`MCU_NUM_TX]
);

    localparam int W     = `MCU_WORD;
    localparam int DIV_W = $clog2(`MCU_BAUD_DIV);

    logic [DIV_W-1:0]       div_cnt;
    logic [`MCU_NUM_TX-1:0] load_now;
    logic [`MCU_NUM_TX-1:0] load_prev;

    // free running oversample divider
    always_ff @(posedge clk50m or negedge rst_n) begin
        if (!rst_n) begin
            div_cnt <= '0;
            tick    <= 1'b0;
        end else begin
            if (div_cnt == DIV_W'(`MCU_BAUD_DIV - 1)) begin
                div_cnt <= '0;
                tick    <= 1'b1;
            end else begin
                div_cnt <= div_cnt + 1'b1;
                tick    <= 1'b0;
            end
        end
    end

    // bit 0 of each channel's load register
    always_comb begin
        for (int c = 0; c < `MCU_NUM_TX; c++) begin
            load_now[c] = regs[(`MCU_REG_TX_LOAD0 + `MCU_REG_CH_STRIDE*c)*W];
        end
    end

    always_ff @(posedge clk50m or negedge rst_n) begin
        if (!rst_n) begin
            load_prev <= '0;
        end else begin
            load_prev <= load_now;
        end
    end

    // rising edge gives a single cycle load with the data byte
    always_comb begin
        for (int c = 0; c < `MCU_NUM_TX; c++) begin
            tx_cmd[c].data = regs[(`MCU_REG_TX_DATA0 + `MCU_REG_CH_STRIDE*c)*W +: 8];
            tx_cmd[c].load = load_now[c] & ~load_prev[c];
        end
    end

endmodule

`default_nettype wire

/* mcu_core.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcu_params.svh"

module mcu_core (
    input  wire logic                                  clk50m,
    input  wire logic                                  rst_n,
    output logic [`MCU_CODE_AW-1:0]                    code_addr,
    input  wire mcu_pkg::instr_t                       instr,
    input  wire logic [`MCU_NUM_DIN*`MCU_WORD-1:0]     din,
    output logic [`MCU_NUM_REGS*`MCU_WORD-1:0]         regs
);
    import mcu_pkg::*;

    localparam int W  = `MCU_WORD;
    localparam int AW = `MCU_CODE_AW;

    mcu_state_e     state;
    logic [AW-1:0]  pc;
    logic [AW-1:0]  pc_next;
    logic [AW-1:0]  jump_target;

    // register bank, only storage in the core
    logic [W-1:0]   rf [`MCU_NUM_REGS];

    logic [W-1:0]   rd_val;
    logic [W-1:0]   src_val;
    logic [W-1:0]   din_val;
    logic [W-1:0]   imm_ext;
    logic [W-1:0]   wr_val;
    logic           wr_en;
    logic           test_bit;

    // rom address comes straight from pc, data valid in exec
    assign code_addr = pc;

    // operand selection
    always_comb begin
        rd_val   = rf[instr.rd];
        src_val  = rf[instr.imm[3:0]];
        din_val  = din[instr.imm[3:0]*W +: W];
        imm_ext  = {{(W-8){1'b0}}, instr.imm};
        test_bit = rd_val[instr.imm[7:4]];
        // signed offset relative to the jump itself
        jump_target = pc + {{(AW-4){instr.imm[3]}}, instr.imm[3:0]};
    end

    // execute stage decode
    always_comb begin
        wr_en   = 1'b0;
        wr_val  = rd_val;
        pc_next = pc + 1'b1;
        case (instr.op)
            OP_LDI: begin
                wr_en  = 1'b1;
                wr_val = imm_ext;
            end
            OP_IN: begin
                wr_en  = 1'b1;
                wr_val = din_val;
            end
            OP_MOV: begin
                wr_en  = 1'b1;
                wr_val = src_val;
            end
            OP_NOT: begin
                wr_en  = 1'b1;
                wr_val = ~src_val;
            end
            OP_ANDI: begin
                wr_en  = 1'b1;
                wr_val = rd_val & imm_ext;
            end
            OP_ADDI: begin
                wr_en  = 1'b1;
                wr_val = rd_val + imm_ext;
            end
            OP_JBZ: begin
                if (!test_bit) begin
                    pc_next = jump_target;
                end
            end
            OP_JBS: begin
                if (test_bit) begin
                    pc_next = jump_target;
                end
            end
            OP_JMP: begin
                // absolute target
                pc_next = instr.imm;
            end
            default: begin
                // unknown opcode falls through as a nop
                wr_en = 1'b0;
            end
        endcase
    end

    // fetch/exec sequencing and writeback
    always_ff @(posedge clk50m or negedge rst_n) begin
        if (!rst_n) begin
            state <= S_FETCH;
            pc    <= '0;
            for (int i = 0; i < `MCU_NUM_REGS; i++) begin
                rf[i] <= '0;
            end
        end else begin
            case (state)
                S_FETCH: begin
                    // rom latches instr at this edge
                    state <= S_EXEC;
                end
                S_EXEC: begin
                    state <= S_FETCH;
                    pc    <= pc_next;
                    if (wr_en) begin
                        rf[instr.rd] <= wr_val;
                    end
                end
                default: begin
                    state <= S_FETCH;
                end
            endcase
        end
    end

    // flatten bank for the peripherals
    always_comb begin
        for (int i = 0; i < `MCU_NUM_REGS; i++) begin
            regs[i*W +: W] = rf[i];
        end
    end

endmodule

`default_nettype wire

/* code_rom.sv */
`timescale 1ns/100ps
`default_nettype none
`include "mcu_params.svh"

module code_rom (
    input  wire logic                    clk50m,
    input  wire logic                    rst_n,
    input  wire logic [`MCU_CODE_AW-1:0] code_addr,
    output mcu_pkg::instr_t              instr
);
    import mcu_pkg::*;

    // register numbers used by the echo program
    localparam logic [3:0] R_EXT  = 4'd1;
    localparam logic [3:0] R_STAT = 4'd2;
    localparam logic [3:0] R_D0   = `MCU_REG_TX_DATA0;
    localparam logic [3:0] R_L0   = `MCU_REG_TX_LOAD0;
    localparam logic [3:0] R_D1   = `MCU_REG_TX_DATA0 + `MCU_REG_CH_STRIDE;
    localparam logic [3:0] R_L1   = `MCU_REG_TX_LOAD0 + `MCU_REG_CH_STRIDE;
    localparam logic [3:0] R_LED  = `MCU_REG_LED;
    localparam logic [3:0] R_ACK  = `MCU_REG_ACK;

    function automatic instr_t rom_word(input logic [`MCU_CODE_AW-1:0] a);
        instr_t w;
        case (a)
            8'd0:    w = '{OP_JMP, 4'd0, 8'd1};
            // wait for strobe, ext_data bit 15
            8'd1:    w = '{OP_IN, R_EXT, 8'(`MCU_DIN_EXT)};
            8'd2:    w = '{OP_JBZ, R_EXT, {4'd15, 4'hf}};
            // low byte to channel 0, inverse to channel 1
            8'd3:    w = '{OP_MOV, R_D0, {4'd0, R_EXT}};
            8'd4:    w = '{OP_ANDI, R_D0, 8'hff};
            8'd5:    w = '{OP_NOT, R_D1, {4'd0, R_D0}};
            8'd6:    w = '{OP_ANDI, R_D1, 8'hff};
            // load pulses, rising edge starts the frame
            8'd7:    w = '{OP_LDI, R_L0, 8'd1};
            8'd8:    w = '{OP_LDI, R_L1, 8'd1};
            8'd9:    w = '{OP_LDI, R_L0, 8'd0};
            8'd10:   w = '{OP_LDI, R_L1, 8'd0};
            // both done flags needed
            8'd11:   w = '{OP_IN, R_STAT, 8'(`MCU_DIN_STATUS)};
            8'd12:   w = '{OP_JBZ, R_STAT, {4'd0, 4'hf}};
            8'd13:   w = '{OP_JBZ, R_STAT, {4'd1, 4'he}};
            // acknowledge and count
            8'd14:   w = '{OP_LDI, R_ACK, 8'd1};
            8'd15:   w = '{OP_LDI, R_ACK, 8'd0};
            8'd16:   w = '{OP_ADDI, R_LED, 8'd1};
            // hold off until the strobe drops
            8'd17:   w = '{OP_IN, R_EXT, 8'(`MCU_DIN_EXT)};
            8'd18:   w = '{OP_JBS, R_EXT, {4'd15, 4'hf}};
            8'd19:   w = '{OP_JMP, 4'd0, 8'd1};
            default: w = '{OP_JMP, 4'd0, 8'd1};
        endcase
        return w;
    endfunction

    // one clock read latency
    always_ff @(posedge clk50m or negedge rst_n) begin
        if (!rst_n) begin
            instr <= rom_word('0);
        end else begin
            instr <= rom_word(code_addr);
        end
    end

endmodule

`default_nettype wire

/* mcu_pkg.sv */
`default_nettype none

package mcu_pkg;

    // opcode set of the core
    typedef enum logic [3:0] {
        OP_LDI  = 4'h0,
        OP_IN   = 4'h1,
        OP_MOV  = 4'h2,
        OP_NOT  = 4'h3,
        OP_ANDI = 4'h4,
        OP_ADDI = 4'h5,
        OP_JBZ  = 4'h6,
        OP_JBS  = 4'h7,
        OP_JMP  = 4'h8
    } mcu_op_e;

    // two cycles per instruction
    typedef enum logic {
        S_FETCH,
        S_EXEC
    } mcu_state_e;

    // 16-bit instruction word
    // jbz/jbs: imm[7:4] bit number, imm[3:0] signed offset from the jump
    typedef struct packed {
        mcu_op_e    op;
        logic [3:0] rd;
        logic [7:0] imm;
    } instr_t;

    // per channel command, load is a single cycle strobe
    typedef struct packed {
        logic [7:0] data;
        logic       load;
    } tx_cmd_t;

    typedef struct packed {
        logic busy;
    } tx_stat_t;

    // 8N1 frame phases
    typedef enum logic [1:0] {
        TX_IDLE,
        TX_START,
        TX_DATA,
        TX_STOP
    } uart_state_e;

endpackage

`default_nettype wire

/* mcu_params.svh */
`ifndef MCU_PARAMS_SVH
`define MCU_PARAMS_SVH

// core sizing
`define MCU_NUM_REGS 16
`define MCU_NUM_DIN 16
`define MCU_WORD 16
`define MCU_CODE_AW 8

// uart channels
`define MCU_NUM_TX 2
// clk50m cycles per oversample tick, about 4x 115200 baud
`define MCU_BAUD_DIV 27
// ticks per serial bit
`define MCU_OVERSAMPLE 4

// register map, channel c sits at base + stride*c
`define MCU_REG_TX_DATA0 8
`define MCU_REG_TX_LOAD0 9
`define MCU_REG_LED 10
`define MCU_REG_ACK 11
`define MCU_REG_CH_STRIDE 4

// data input slots
`define MCU_DIN_STATUS 0
`define MCU_DIN_EXT 2

`endif
